//--- Makefile
# Verilator build for the hello beacon testbench
# any variable can be overridden on the command line, for example make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_hello_uart
LOG       ?= sim.log
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --top-module $(TOP) -f $(FLIST)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- flist.f
hw/hello_pkg.sv
hw/uart_baud_timer.sv
hw/uart_frame_tx.sv
hw/message_source.sv
hw/hello_uart_top.sv
+incdir+test
test/tb_hello_uart.sv

//--- hw/hello_pkg.sv
// shared constants for the hello beacon; clocks-per-bit must be at least 2 and the greeting is exactly MSG_LENGTH bytes
package hello_pkg;

	//////////////////////////////////////////////////
	// baud and character widths
	//////////////////////////////////////////////////

	// clocks-per-bit as presented on the setting ports
	localparam int BAUD_WIDTH = 24;
	// four bits wider than the setting so that sixteen bit times still fit
	localparam int BAUD_COUNT_WIDTH = 28;

	typedef logic [7:0] byte_t;
	typedef logic [BAUD_WIDTH-1:0] baud_t;

	// word length code, 0 sends eight data bits and 3 sends only five
	typedef logic [1:0] data_bits_t;

	// frame states
	// the data states count up to BIT_SEVEN, so a shorter word simply starts later
	// in the sequence, and bit 3 of the code tells data states from the rest
	typedef enum logic [3:0] {
		BIT_ZERO    = 4'h0,
		BIT_ONE     = 4'h1,
		BIT_TWO     = 4'h2,
		BIT_THREE   = 4'h3,
		BIT_FOUR    = 4'h4,
		BIT_FIVE    = 4'h5,
		BIT_SIX     = 4'h6,
		BIT_SEVEN   = 4'h7,
		PARITY      = 4'h8,
		STOP        = 4'h9,
		SECOND_STOP = 4'ha,
		BREAK       = 4'he,
		IDLE        = 4'hf
	} tx_state_t;

	//////////////////////////////////////////////////
	// greeting
	//////////////////////////////////////////////////

	localparam int MSG_LENGTH = 16;
	localparam int MSG_INDEX_WIDTH = 4;

	// the last two entries are carriage return and line feed
	localparam byte_t MESSAGE [0:MSG_LENGTH-1] = '{
		"H", "e", "l", "l", "o", ",", " ", "W",
		"o", "r", "l", "d", "!", " ", 8'h0d, 8'h0a
	};

	//////////////////////////////////////////////////
	// timing constants
	//////////////////////////////////////////////////

	// the greeting repeats every 2^TRIGGER_WIDTH clocks
	localparam int TRIGGER_WIDTH = 14;
	// clocks from reset release to the first greeting
	localparam int TRIGGER_LEAD = 16;
	// idle bit times after reset, also the hold interval while a break is asserted
	localparam int RESET_GUARD_BITS = 16;
	// idle bit times after a break is released, before busy drops
	localparam int BREAK_TAIL_BITS = 4;
	// the led stays lit for 2^(LED_WIDTH-1) clocks after the line was last low
	localparam int LED_WIDTH = 25;

endpackage

//--- hw/hello_uart_top.sv
// hello beacon top level; settings reach the line only between frames and o_led is active high
`timescale 1ns/1ps

module hello_uart_top import hello_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_break,
	input  logic       i_cts_n,
	input  baud_t      i_clocks_per_baud,
	input  data_bits_t i_data_bits,
	input  logic       i_two_stop,
	input  logic       i_parity_en,
	input  logic       i_parity_fixed,
	input  logic       i_parity_sel,
	input  logic       i_hw_flow,
	output logic       o_uart_tx,
	output logic       o_led
);

	logic                 tx_wr;
	byte_t                tx_data;
	logic                 tx_busy;
	logic                 tx_line;
	logic [LED_WIDTH-1:0] led_ctr;

	//////////////////////////////////////////////////
	// source and transmitter
	//////////////////////////////////////////////////

	message_source u_source (
		.i_clk   (i_clk),
		.i_reset (i_reset),
		.i_busy  (tx_busy),
		.o_wr    (tx_wr),
		.o_data  (tx_data)
	);

	uart_frame_tx u_tx (
		.i_clk             (i_clk),
		.i_reset           (i_reset),
		.i_break           (i_break),
		.i_wr              (tx_wr),
		.i_data            (tx_data),
		.i_cts_n           (i_cts_n),
		.i_clocks_per_baud (i_clocks_per_baud),
		.i_data_bits       (i_data_bits),
		.i_two_stop        (i_two_stop),
		.i_parity_en       (i_parity_en),
		.i_parity_fixed    (i_parity_fixed),
		.i_parity_sel      (i_parity_sel),
		.i_hw_flow         (i_hw_flow),
		.o_uart_tx         (tx_line),
		.o_busy            (tx_busy)
	);

	assign o_uart_tx = tx_line;

	//////////////////////////////////////////////////
	// activity led
	//////////////////////////////////////////////////

	// any low bit on the line restarts the count, the top bit ends the glow
	// and the counter then sits at all ones until the line moves again
	always_ff @(posedge i_clk)
		if (i_reset)
			led_ctr <= '1;
		else if (!tx_line)
			led_ctr <= '0;
		else if (led_ctr != {LED_WIDTH{1'b1}})
			led_ctr <= led_ctr + LED_WIDTH'(1);

	assign o_led = !led_ctr[LED_WIDTH-1];

endmodule

//--- hw/message_source.sv
// greeting source; waits on i_busy without limit, so a held break or clear-to-send only delays the text
`timescale 1ns/1ps

module message_source import hello_pkg::*; (
	input  logic  i_clk,
	input  logic  i_reset,
	input  logic  i_busy,
	output logic  o_wr,
	output byte_t o_data
);

	logic [TRIGGER_WIDTH-1:0]   trigger_ctr;
	logic [MSG_INDEX_WIDTH-1:0] msg_index;
	logic                       accept;
	logic                       last_char;

	//////////////////////////////////////////////////
	// repeat trigger
	//////////////////////////////////////////////////

	// starts TRIGGER_LEAD counts short of all ones so the first greeting
	// goes out soon after reset, then the counter simply wraps
	always_ff @(posedge i_clk)
		if (i_reset)
			trigger_ctr <= {TRIGGER_WIDTH{1'b1}} - TRIGGER_WIDTH'(TRIGGER_LEAD);
		else
			trigger_ctr <= trigger_ctr + TRIGGER_WIDTH'(1);

	//////////////////////////////////////////////////
	// character stepping
	//////////////////////////////////////////////////

	// the transmitter takes the character on any cycle with strobe high and busy low
	assign accept = o_wr && !i_busy;
	assign last_char = (msg_index == MSG_INDEX_WIDTH'(MSG_LENGTH - 1));

	// the index wraps to zero after the line feed
	always_ff @(posedge i_clk)
		if (i_reset)
			msg_index <= '0;
		else if (accept)
			msg_index <= msg_index + MSG_INDEX_WIDTH'(1);

	// one cycle behind the index, which is early enough because busy
	// covers a whole frame after each acceptance
	always_ff @(posedge i_clk)
		o_data <= MESSAGE[msg_index];

	// strobe stays up for the whole greeting and drops after the final character
	always_ff @(posedge i_clk)
		if (i_reset)
			o_wr <= 1'b0;
		else if (&trigger_ctr)
			o_wr <= 1'b1;
		else if (accept && last_char)
			o_wr <= 1'b0;

endmodule

//--- hw/uart_baud_timer.sv
// bit timer for the transmitter; i_clocks_per_baud must be at least 2 and held stable outside IDLE
`timescale 1ns/1ps

module uart_baud_timer import hello_pkg::*; (
	input  logic      i_clk,
	input  logic      i_reset,
	input  logic      i_break,
	input  baud_t     i_clocks_per_baud,
	input  tx_state_t i_state,
	input  logic      i_start,
	output logic      o_bit_tick
);

	//////////////////////////////////////////////////
	// reload values
	//////////////////////////////////////////////////

	logic [BAUD_COUNT_WIDTH-1:0] baud_counter;
	logic [BAUD_COUNT_WIDTH-1:0] bit_count;
	logic [BAUD_COUNT_WIDTH-1:0] guard_count;
	logic [BAUD_COUNT_WIDTH-1:0] tail_count;
	logic                        bit_tick;

	// one bit time, minus the cycle spent on the tick itself
	assign bit_count = BAUD_COUNT_WIDTH'(i_clocks_per_baud) - BAUD_COUNT_WIDTH'(1);

	// long idle stretch after reset and while a break is held
	assign guard_count = BAUD_COUNT_WIDTH'(i_clocks_per_baud)
		* BAUD_COUNT_WIDTH'(RESET_GUARD_BITS);

	// short idle stretch once a break has been released
	assign tail_count = BAUD_COUNT_WIDTH'(i_clocks_per_baud)
		* BAUD_COUNT_WIDTH'(BREAK_TAIL_BITS);

	//////////////////////////////////////////////////
	// counter and tick flag
	//////////////////////////////////////////////////

	// the tick is registered from a compare against one, so it rises on the
	// very cycle the counter would have reached zero
	always_ff @(posedge i_clk)
	begin
		bit_tick <= (baud_counter == BAUD_COUNT_WIDTH'(1));
		if (i_reset || i_break)
		begin
			baud_counter <= guard_count;
			bit_tick <= 1'b0;
		end
		else if (i_state == BREAK)
		begin
			// break just released, the frame logic moves on to IDLE this cycle
			baud_counter <= tail_count;
			bit_tick <= 1'b0;
		end
		else if (!bit_tick)
			baud_counter <= baud_counter - BAUD_COUNT_WIDTH'(1);
		else if (i_state == IDLE)
		begin
			if (i_start)
			begin
				// start bit begins now and lasts one full bit time
				baud_counter <= bit_count;
				bit_tick <= 1'b0;
			end
			else
			begin
				// parked with the tick high so a write is taken at once
				baud_counter <= '0;
				bit_tick <= 1'b1;
			end
		end
		else
			baud_counter <= bit_count;
	end

	assign o_bit_tick = bit_tick;

endmodule

//--- hw/uart_frame_tx.sv
// uart transmitter without buffering; a write while o_busy is high is ignored and settings apply from the next frame
`timescale 1ns/1ps

module uart_frame_tx import hello_pkg::*; (
	input  logic       i_clk,
	input  logic       i_reset,
	input  logic       i_break,
	input  logic       i_wr,
	input  byte_t      i_data,
	input  logic       i_cts_n,
	input  baud_t      i_clocks_per_baud,
	input  data_bits_t i_data_bits,
	input  logic       i_two_stop,
	input  logic       i_parity_en,
	input  logic       i_parity_fixed,
	input  logic       i_parity_sel,
	input  logic       i_hw_flow,
	output logic       o_uart_tx,
	output logic       o_busy
);

	baud_t      r_clocks_per_baud;
	data_bits_t r_data_bits;
	logic       r_two_stop;
	logic       r_parity_en;
	logic       r_parity_fixed;
	logic       r_parity_sel;
	logic       r_hw_flow;
	logic       q_cts_n;
	logic       qq_cts_n;
	logic       ck_cts;
	tx_state_t  state;
	logic       r_busy;
	byte_t      lcl_data;
	logic       calc_parity;
	logic       bit_tick;
	logic       start;

	// a character is taken whenever the strobe meets a free transmitter
	assign start = i_wr && !r_busy;

	//////////////////////////////////////////////////
	// settings and clear-to-send
	//////////////////////////////////////////////////

	// the settings follow the ports only between frames
	always_ff @(posedge i_clk)
		if (state == IDLE)
		begin
			r_clocks_per_baud <= i_clocks_per_baud;
			r_data_bits <= i_data_bits;
			r_two_stop <= i_two_stop;
			r_parity_en <= i_parity_en;
			r_parity_fixed <= i_parity_fixed;
			r_parity_sel <= i_parity_sel;
			r_hw_flow <= i_hw_flow;
		end

	// two flops bring i_cts_n into this clock domain, a third forms the permission
	always_ff @(posedge i_clk)
	begin
		q_cts_n <= i_cts_n;
		qq_cts_n <= q_cts_n;
		ck_cts <= !qq_cts_n || !r_hw_flow;
	end

	uart_baud_timer u_baud_timer (
		.i_clk             (i_clk),
		.i_reset           (i_reset),
		.i_break           (i_break),
		.i_clocks_per_baud (r_clocks_per_baud),
		.i_state           (state),
		.i_start           (start),
		.o_bit_tick        (bit_tick)
	);

	//////////////////////////////////////////////////
	// frame state machine
	//////////////////////////////////////////////////

	// the state names the bit that goes out at the next tick, so during the
	// start bit the state already points at the first data bit
	always_ff @(posedge i_clk)
	begin
		if (i_reset)
		begin
			state <= IDLE;
			r_busy <= 1'b1;
		end
		else if (i_break)
		begin
			state <= BREAK;
			r_busy <= 1'b1;
		end
		else if (state == BREAK)
		begin
			// the timer loads the tail interval on this same cycle
			state <= IDLE;
			r_busy <= 1'b1;
		end
		else if (!bit_tick)
			r_busy <= 1'b1;
		else if (state == IDLE)
		begin
			if (start)
			begin
				r_busy <= 1'b1;
				// shorter words skip the low data states
				case (r_data_bits)
					2'b00: state <= BIT_ZERO;
					2'b01: state <= BIT_ONE;
					2'b10: state <= BIT_TWO;
					2'b11: state <= BIT_THREE;
				endcase
			end
			else
				r_busy <= !ck_cts;
		end
		else
		begin
			r_busy <= 1'b1;
			if (!state[3])
				state <= (state == BIT_SEVEN) ? (r_parity_en ? PARITY : STOP)
					: tx_state_t'(state + 4'd1);
			else if (state == PARITY)
				state <= STOP;
			else if (state == STOP)
				state <= r_two_stop ? SECOND_STOP : IDLE;
			else
				state <= IDLE;
		end
	end

	assign o_busy = r_busy;

	//////////////////////////////////////////////////
	// data, parity and line
	//////////////////////////////////////////////////

	// shifts right at each tick so bit 0 is always the next data bit
	always_ff @(posedge i_clk)
		if (!r_busy)
			lcl_data <= i_data;
		else if (bit_tick)
			lcl_data <= {1'b0, lcl_data[7:1]};

	// running xor of the bits actually sent, seeded with the select bit
	always_ff @(posedge i_clk)
		if (r_parity_fixed)
			calc_parity <= r_parity_sel;
		else if (bit_tick)
			calc_parity <= !state[3] ? (calc_parity ^ lcl_data[0]) : r_parity_sel;

	// low for break or start, data and parity at their ticks, high otherwise
	always_ff @(posedge i_clk)
		if (i_reset)
			o_uart_tx <= 1'b1;
		else if (i_break || start)
			o_uart_tx <= 1'b0;
		else if (state == BREAK)
			o_uart_tx <= 1'b1;
		else if (bit_tick)
		begin
			if (!state[3])
				o_uart_tx <= lcl_data[0];
			else if (state == PARITY)
				o_uart_tx <= calc_parity;
			else
				o_uart_tx <= 1'b1;
		end

endmodule

//--- test/hello_stimulus.txt
# name cpb word_code two_stop par_en par_fixed par_sel hw_flow action action_index
#   new_word_code new_par_en new_par_fixed new_par_sel parity_bits(hex, bit i = char i) char0..char15(hex)
# word code 0 is 8 bits, 1 is 7, 2 is 6, 3 is 5
# action 0 none, 1 hold cts after that char, 2 hold cts and pulse break, 3 random mid-frame change
#
# plain 8 data bits, no parity, one stop
plain_8n1 8 0 0 0 0 0 0 0 0 0 0 0 0 0000 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
#
# parity modes over 7, 6 and 5 data bits
odd_7 8 1 0 1 0 0 0 0 0 0 0 0 0 68e0 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
even_7 8 1 0 1 0 1 0 0 0 0 0 0 0 971f 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
even_6_two 6 2 1 1 0 1 0 0 0 0 0 0 0 9880 08 25 2c 2c 2f 2c 20 17 2f 32 2c 24 21 20 0d 0a
odd_6 6 2 0 1 0 0 0 0 0 0 0 0 0 677f 08 25 2c 2c 2f 2c 20 17 2f 32 2c 24 21 20 0d 0a
odd_5 4 3 0 1 0 0 0 0 0 0 0 0 0 5801 08 05 0c 0c 0f 0c 00 17 0f 12 0c 04 01 00 0d 0a
mark_5 8 3 0 1 1 1 0 0 0 0 0 0 0 ffff 08 05 0c 0c 0f 0c 00 17 0f 12 0c 04 01 00 0d 0a
space_8_two 6 0 1 1 1 0 0 0 0 0 0 0 0 0000 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
even_8 10 0 0 1 0 1 0 0 0 0 0 0 0 971f 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
#
# settings change inside frame 5, later frames use 5 bits with parity select 1
change_mid 8 0 0 0 0 0 0 3 5 3 1 0 1 a7c0 48 65 6c 6c 6f 2c 00 17 0f 12 0c 04 01 00 0d 0a
#
# flow control hold, then flow control hold with a break while idle
cts_hold 8 0 0 0 0 0 1 1 3 0 0 0 0 0000 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a
break_hold 8 0 0 1 0 0 1 2 9 0 0 0 0 68e0 48 65 6c 6c 6f 2c 20 57 6f 72 6c 64 21 20 0d 0a

//--- test/tb_line_decoder.svh
// serial line decoder tasks, included inside the testbench module; needs i_clk and uart_tx declared first, clocks-per-bit at least 4
`ifndef TB_LINE_DECODER_SVH
`define TB_LINE_DECODER_SVH

//////////////////////////////////////////////////
// start bit detection
//////////////////////////////////////////////////

// the line is only looked at on falling clock edges, where it is stable
// a frame begins where a high line goes low
task automatic wait_start_bit();
	@(negedge i_clk);
	while (uart_tx !== 1'b1)
		@(negedge i_clk);
	while (uart_tx !== 1'b0)
		@(negedge i_clk);
endtask

//////////////////////////////////////////////////
// frame body
//////////////////////////////////////////////////

// called on the negedge that first saw the start bit low
// the first wait lands near the middle of the start bit, and every later
// sample is one full bit time on, so each bit is read close to its centre
task automatic read_frame(
	input  int    cpb,
	input  int    nbits,
	input  logic  with_parity,
	input  logic  two_stop,
	output logic  start_bit,
	output byte_t data,
	output logic  parity_bit,
	output logic  stop_one,
	output logic  stop_two
);
	int b;
	data = '0;
	parity_bit = 1'b0;
	stop_two = 1'b1;
	repeat (cpb / 2) @(negedge i_clk);
	start_bit = uart_tx;
	// least significant bit first, shifted in from the top
	for (b = 0; b < nbits; b++)
	begin
		repeat (cpb) @(negedge i_clk);
		data = {uart_tx, data[7:1]};
	end
	// short words end up in the high bits, move them down
	data = data >> (8 - nbits);
	if (with_parity)
	begin
		repeat (cpb) @(negedge i_clk);
		parity_bit = uart_tx;
	end
	repeat (cpb) @(negedge i_clk);
	stop_one = uart_tx;
	if (two_stop)
	begin
		repeat (cpb) @(negedge i_clk);
		stop_two = uart_tx;
	end
endtask

`endif

//--- test/tb_hello_uart.sv
// testbench for the hello beacon; run from the project root so test/hello_stimulus.txt is found, each test uses one greeting
`timescale 1ns/1ps

module tb_hello_uart import hello_pkg::*; ();

	logic       i_clk;
	logic       i_reset;
	logic       i_break;
	logic       i_cts_n;
	baud_t      i_clocks_per_baud;
	data_bits_t i_data_bits;
	logic       i_two_stop;
	logic       i_parity_en;
	logic       i_parity_fixed;
	logic       i_parity_sel;
	logic       i_hw_flow;
	logic       uart_tx;
	logic       led;

	// one entry per stimulus line
	string       t_name [0:31];
	int          t_field [0:31][0:12];
	logic [15:0] t_parity [0:31];
	byte_t       t_chars [0:31][0:15];
	int          num_tests = 0;
	logic        tests_loaded = 1'b0;
	int          error_count = 0;
	int          seed = 9;

	hello_uart_top u_dut (
		.i_clk             (i_clk),
		.i_reset           (i_reset),
		.i_break           (i_break),
		.i_cts_n           (i_cts_n),
		.i_clocks_per_baud (i_clocks_per_baud),
		.i_data_bits       (i_data_bits),
		.i_two_stop        (i_two_stop),
		.i_parity_en       (i_parity_en),
		.i_parity_fixed    (i_parity_fixed),
		.i_parity_sel      (i_parity_sel),
		.i_hw_flow         (i_hw_flow),
		.o_uart_tx         (uart_tx),
		.o_led             (led)
	);

	`include "tb_line_decoder.svh"

	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		if (expected !== actual)
		begin
			error_count++;
			$display("FAIL %s expected %b actual %b", name, expected, actual);
			$display("TB FAILED");
			$fatal(1);
		end
	endtask

	//////////////////////////////////////////////////
	// stimulus file and settings
	//////////////////////////////////////////////////

	// fields are cpb, word code, two stop, parity enable, fixed, select, flow,
	// action, action index, then the word code and parity of a mid-frame change
	task automatic load_tests();
		int          fd;
		int          n;
		int          k;
		string       line;
		string       name;
		int          f [0:12];
		logic [15:0] par;
		int          c [0:15];
		fd = $fopen("test/hello_stimulus.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file test/hello_stimulus.txt");
			$display("TB FAILED");
			$fatal(1);
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line,
				"%s %d %d %d %d %d %d %d %d %d %d %d %d %d %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				name, f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
				f[11], f[12], par, c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7],
				c[8], c[9], c[10], c[11], c[12], c[13], c[14], c[15]);
			if (n != 31)
			begin
				$display("a stimulus line could not be parsed: %s", line);
				$display("TB FAILED");
				$fatal(1);
			end
			t_name[num_tests] = name;
			t_parity[num_tests] = par;
			for (k = 0; k < 13; k++)
				t_field[num_tests][k] = f[k];
			for (k = 0; k < 16; k++)
				t_chars[num_tests][k] = byte_t'(c[k]);
			num_tests++;
		end
		$fclose(fd);
	endtask

	task automatic apply_settings(input int t);
		@(posedge i_clk);
		i_clocks_per_baud <= baud_t'(t_field[t][0]);
		i_data_bits <= data_bits_t'(t_field[t][1]);
		i_two_stop <= (t_field[t][2] != 0);
		i_parity_en <= (t_field[t][3] != 0);
		i_parity_fixed <= (t_field[t][4] != 0);
		i_parity_sel <= (t_field[t][5] != 0);
		i_hw_flow <= (t_field[t][6] != 0);
	endtask

	// runs beside the decoder while frame i is on the line
	task automatic mid_frame_action(input int t, input int i, input int frame_cycles);
		int wait_cycles;
		if (i != t_field[t][8])
			return;
		if (t_field[t][7] == 1 || t_field[t][7] == 2)
		begin
			// holds the next character back once this frame ends
			@(posedge i_clk);
			i_cts_n <= 1'b1;
		end
		else if (t_field[t][7] == 3)
		begin
			wait_cycles = (($random(seed) & 32'h7fff_ffff) % frame_cycles) + 1;
			repeat (wait_cycles) @(posedge i_clk);
			i_data_bits <= data_bits_t'(t_field[t][9]);
			i_parity_en <= (t_field[t][10] != 0);
			i_parity_fixed <= (t_field[t][11] != 0);
			i_parity_sel <= (t_field[t][12] != 0);
		end
	endtask

	// line must stay idle while clear-to-send is high, and low through a break
	task automatic hold_and_release(input int t);
		int cpb;
		cpb = t_field[t][0];
		repeat (24 * cpb)
		begin
			@(negedge i_clk);
			compare_bit({t_name[t], " idle under cts"}, 1'b1, uart_tx);
		end
		if (t_field[t][7] == 2)
		begin
			@(posedge i_clk);
			i_break <= 1'b1;
			@(posedge i_clk);
			repeat (8 * cpb)
			begin
				@(negedge i_clk);
				compare_bit({t_name[t], " break level"}, 1'b0, uart_tx);
			end
			@(posedge i_clk);
			i_break <= 1'b0;
			repeat (cpb) @(posedge i_clk);
		end
		@(posedge i_clk);
		i_cts_n <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// watchdog
	//////////////////////////////////////////////////

	// each test needs at most one greeting period plus its stalls
	initial
	begin
		wait (tests_loaded);
		repeat (num_tests * (2 ** TRIGGER_WIDTH) * 2) @(posedge i_clk);
		$display("the run did not finish in time, the line stopped sending");
		$display("TB FAILED");
		$fatal(1);
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial
	begin
		int    t;
		int    i;
		int    cur_nbits;
		int    frame_cycles;
		logic  cur_par;
		logic  start_bit;
		logic  par_bit;
		logic  stop_one;
		logic  stop_two;
		byte_t data;
		string where;
		i_reset = 1'b1;
		i_break = 1'b0;
		i_cts_n = 1'b0;
		i_clocks_per_baud = baud_t'(8);
		i_data_bits = '0;
		i_two_stop = 1'b0;
		i_parity_en = 1'b0;
		i_parity_fixed = 1'b0;
		i_parity_sel = 1'b0;
		i_hw_flow = 1'b0;
		load_tests();
		tests_loaded = 1'b1;
		repeat (4) @(posedge i_clk);
		i_reset <= 1'b0;
		@(negedge i_clk);
		compare_bit("led after reset", 1'b0, led);
		for (t = 0; t < num_tests; t++)
		begin
			apply_settings(t);
			cur_nbits = 8 - t_field[t][1];
			cur_par = (t_field[t][3] != 0);
			for (i = 0; i < MSG_LENGTH; i++)
			begin
				frame_cycles = (1 + cur_nbits) * t_field[t][0];
				wait_start_bit();
				fork
					read_frame(t_field[t][0], cur_nbits, cur_par, i_two_stop,
						start_bit, data, par_bit, stop_one, stop_two);
					mid_frame_action(t, i, frame_cycles);
				join
				where = $sformatf("%s char %0d", t_name[t], i);
				compare_bit({where, " start"}, 1'b0, start_bit);
				compare_byte({where, " data"}, t_chars[t][i], data);
				if (cur_par)
					compare_bit({where, " parity"}, t_parity[t][i[3:0]], par_bit);
				compare_bit({where, " stop"}, 1'b1, stop_one);
				if (t_field[t][2] != 0)
					compare_bit({where, " second stop"}, 1'b1, stop_two);
				if (t == 0 && i == 0)
					compare_bit("led after start bit", 1'b1, led);
				if (i == t_field[t][8] && t_field[t][7] == 3)
				begin
					// the changed settings belong to the following frames
					cur_nbits = 8 - t_field[t][9];
					cur_par = (t_field[t][10] != 0);
				end
				if (i == t_field[t][8] && (t_field[t][7] == 1 || t_field[t][7] == 2))
					hold_and_release(t);
			end
		end
		if (error_count == 0)
		begin
			$display("TB PASSED");
			$finish;
		end
		else
		begin
			$display("TB FAILED");
			$fatal(1);
		end
	end

endmodule
